// ==== files.f ====
+incdir+verilog
verilog/addr_xbar_pkg.sv
verilog/addr_map_regs.sv
verilog/addr_decode_dync.sv
verilog/addr_req_router.sv
verilog/addr_xbar_top.sv
bench/tb_addr_xbar.sv

// ==== Bender.yml ====
package:
  name: addr_xbar

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/addr_xbar_pkg.sv
      - verilog/addr_map_regs.sv
      - verilog/addr_decode_dync.sv
      - verilog/addr_req_router.sv
      - verilog/addr_xbar_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_addr_xbar.sv

// ==== bench/tb_addr_xbar.sv ====
// Address crossbar testbench
// Directed tests against a reference model of the range map, one task per behavior
`timescale 1ns/100ps
`default_nettype none

`include "addr_xbar_consts.svh"

module tb_addr_xbar;

  import addr_xbar_pkg::*;

  // Expected outcome of one request, fixed when the request is issued
  typedef struct packed {
    logic is_err;
    logic busy;
    idx_t port;
    req_t req;
  } exp_t;

  logic                            clk = 1'b0;
  logic                            arst_n;
  logic                            cfg_we;
  cfg_wr_t                         cfg_wr;
  logic                            req_valid;
  req_t                            req;
  logic [`ADDR_XBAR_NUM_PORTS-1:0] port_valid;
  req_t                            port_req;
  logic                            err_valid;
  err_t                            err;

  // Reference copy of the map as the bench wrote it
  rule_t m_rules [`ADDR_XBAR_NUM_RULES];
  logic  m_en_def;
  idx_t  m_def_idx;
  logic  m_updating;

  req_t        stim_q [$];
  logic [15:0] lfsr;

  addr_xbar_top u_addr_xbar_top (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .cfg_we_i     (cfg_we),
    .cfg_wr_i     (cfg_wr),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .port_valid_o (port_valid),
    .port_req_o   (port_req),
    .err_valid_o  (err_valid),
    .err_o        (err)
  );

  always #10 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic report_value(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
    fail_run($sformatf("ERR time %0t %s got 0x%0h expected 0x%0h", $time, name, got,
                       expected));
  endtask

  // Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step for every bit taken, the bits fill the word from the bottom
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // Highest-numbered matching rule wins, so search from the top down
  function automatic exp_t predict(input req_t r);
    exp_t e;
    logic hit;
    e     = '0;
    e.req = r;
    hit   = 1'b0;
    if (m_updating) begin
      e.is_err = 1'b1;
      e.busy   = 1'b1;
      return e;
    end
    for (int i = `ADDR_XBAR_NUM_RULES - 1; i >= 0; i--) begin
      if (!hit && (r.addr >= m_rules[i].start_addr) &&
          ((m_rules[i].end_addr == '0) || (r.addr < m_rules[i].end_addr))) begin
        hit    = 1'b1;
        e.port = m_rules[i].idx;
      end
    end
    if (!hit) begin
      e.port   = m_def_idx;
      e.is_err = !m_en_def;
    end
    return e;
  endfunction

  // Single strobe, starts and ends on a falling edge
  task automatic cfg_write(input int unsigned reg_addr, input data_t wdata);
    cfg_we          = 1'b1;
    cfg_wr.reg_addr = cfg_addr_t'(reg_addr);
    cfg_wr.wdata    = wdata;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic set_rule(input int unsigned r, input addr_t s, input addr_t e, input idx_t idx);
    cfg_write(r * `ADDR_XBAR_RULE_STRIDE + `ADDR_XBAR_FLD_START, s);
    cfg_write(r * `ADDR_XBAR_RULE_STRIDE + `ADDR_XBAR_FLD_END, e);
    cfg_write(r * `ADDR_XBAR_RULE_STRIDE + `ADDR_XBAR_FLD_IDX, data_t'(idx));
    m_rules[r].start_addr = s;
    m_rules[r].end_addr   = e;
    m_rules[r].idx        = idx;
    m_updating            = 1'b1;
  endtask

  task automatic commit_map();
    cfg_write(`ADDR_XBAR_REG_COMMIT, '0);
    m_updating = 1'b0;
  endtask

  task automatic push_req(input addr_t a, input data_t d);
    stim_q.push_back(req_t'{addr: a, data: d});
  endtask

  task automatic check_idle();
    assert (port_valid === '0) else report_value("port_valid_o", port_valid, 0);
    assert (err_valid === 1'b0) else report_value("err_valid_o", err_valid, 0);
  endtask

  task automatic check_result(input exp_t e);
    logic [`ADDR_XBAR_NUM_PORTS-1:0] onehot;
    onehot = '0;
    if (e.is_err) begin
      assert (err_valid === 1'b1) else report_value("err_valid_o", err_valid, 1);
      assert (port_valid === '0) else report_value("port_valid_o", port_valid, 0);
      assert (err.addr === e.req.addr) else report_value("err_o.addr", err.addr, e.req.addr);
      assert (err.busy === e.busy) else report_value("err_o.busy", err.busy, e.busy);
    end else begin
      onehot[e.port] = 1'b1;
      assert (port_valid === onehot) else report_value("port_valid_o", port_valid, onehot);
      assert (err_valid === 1'b0) else report_value("err_valid_o", err_valid, 0);
      assert (port_req === e.req) else report_value("port_req_o", port_req, e.req);
    end
  endtask

  // Issues the queued requests on consecutive cycles, each result is due one cycle later
  task automatic run_stim();
    exp_t pend_q [$];
    int   cycles;
    int   limit;
    cycles = 0;
    limit  = stim_q.size() + 4;
    while ((stim_q.size() > 0) || (pend_q.size() > 0)) begin
      if (pend_q.size() > 0) begin
        check_result(pend_q.pop_front());
      end else begin
        check_idle();
      end
      if (stim_q.size() > 0) begin
        req       = stim_q.pop_front();
        req_valid = 1'b1;
        pend_q.push_back(predict(req));
      end else begin
        req_valid = 1'b0;
      end
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        fail_run("Timeout while waiting for request results");
      end
    end
    // Each request gives exactly one strobe
    check_idle();
  endtask

  task automatic test_reset_error();
    check_idle();
    push_req(32'h0000_1234, 32'hA5A5_0001);
    run_stim();
  endtask

  task automatic test_disjoint_rules();
    set_rule(0, 32'h0000_1000, 32'h0000_2000, 2'd3);
    set_rule(1, 32'h0000_2000, 32'h0000_3000, 2'd2);
    set_rule(2, 32'h0000_8000, 32'h0000_9000, 2'd1);
    set_rule(3, 32'h0001_0000, 32'h0002_0000, 2'd0);
    commit_map();
    push_req(32'h0000_1000, 32'h1111_0000);
    push_req(32'h0000_1FFF, 32'h1111_0001);
    push_req(32'h0000_2000, 32'h2222_0000);
    push_req(32'h0000_8ABC, 32'h3333_0000);
    push_req(32'h0001_FFFF, 32'h4444_0000);
    // Holes between and around the ranges
    push_req(32'h0000_0000, 32'h5555_0000);
    push_req(32'h0000_3000, 32'h5555_0001);
    push_req(32'h0000_9000, 32'h5555_0002);
    push_req(32'hFFFF_FFFF, 32'h5555_0003);
    run_stim();
  endtask

  task automatic test_overlap_rules();
    set_rule(1, 32'h4000_0000, 32'h5000_0000, 2'd1);
    set_rule(3, 32'h4800_0000, 32'h0000_0000, 2'd2);
    commit_map();
    push_req(32'h4100_0000, 32'h6666_0000);
    push_req(32'h4900_0000, 32'h6666_0001);
    push_req(32'hFFFF_FFFF, 32'h6666_0002);
    push_req(32'h3FFF_FFFF, 32'h6666_0003);
    run_stim();
  endtask

  task automatic test_default_port();
    logic [31:0] r;
    cfg_write(`ADDR_XBAR_REG_CTRL, (32'd2 << 1) | 32'd1);
    m_en_def  = 1'b1;
    m_def_idx = 2'd2;
    push_req(32'h0000_0000, 32'h7777_0000);
    push_req(32'h0000_3000, 32'h7777_0001);
    // Random addresses inside the unmapped window from 0x1000_0000 upward
    for (int i = 0; i < 8; i++) begin
      rand_bits(28, r);
      push_req(32'h1000_0000 | {4'h0, r[27:0]}, 32'h7777_0100 + i);
    end
    run_stim();
  endtask

  task automatic test_update_busy();
    // Rewriting one field opens an update
    cfg_write(`ADDR_XBAR_FLD_START, 32'h0000_1000);
    m_rules[0].start_addr = 32'h0000_1000;
    m_updating            = 1'b1;
    for (int pass = 0; pass < 2; pass++) begin
      push_req(32'h0000_1800, 32'h8888_0000);
      push_req(32'h4100_0000, 32'h8888_0001);
      push_req(32'h1234_5678, 32'h8888_0002);
      run_stim();
      if (pass == 0) begin
        commit_map();
      end
    end
  endtask

  task automatic test_back_to_back();
    logic [31:0] a;
    logic [31:0] d;
    for (int i = 0; i < 12; i++) begin
      rand_bits(32, a);
      rand_bits(32, d);
      push_req(a, d);
    end
    run_stim();
  endtask

  initial begin
    arst_n     = 1'b0;
    cfg_we     = 1'b0;
    cfg_wr     = '0;
    req_valid  = 1'b0;
    req        = '0;
    lfsr       = 16'd19201;
    m_en_def   = 1'b0;
    m_def_idx  = '0;
    m_updating = 1'b0;
    for (int i = 0; i < `ADDR_XBAR_NUM_RULES; i++) begin
      m_rules[i] = rule_t'{idx: '0, start_addr: addr_t'(1), end_addr: addr_t'(1)};
    end
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    test_reset_error();
    test_disjoint_rules();
    test_overlap_rules();
    test_default_port();
    test_update_busy();
    test_back_to_back();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/addr_xbar_top.sv ====
// Address crossbar request side
// Register file for the live map feeding the request router and its decoder
`timescale 1ns/100ps
`default_nettype none

`include "addr_xbar_consts.svh"

module addr_xbar_top (
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  // Configuration write strobe
  input  wire logic                       cfg_we_i,
  input  addr_xbar_pkg::cfg_wr_t          cfg_wr_i,
  // Request strobe
  input  wire logic                       req_valid_i,
  input  addr_xbar_pkg::req_t             req_i,
  // Routed request or error, one cycle after the request
  output logic [`ADDR_XBAR_NUM_PORTS-1:0] port_valid_o,
  output addr_xbar_pkg::req_t             port_req_o,
  output logic                            err_valid_o,
  output addr_xbar_pkg::err_t             err_o
);

  import addr_xbar_pkg::*;

  // Live map between the register file and the router
  rule_t [`ADDR_XBAR_NUM_RULES-1:0] addr_map;
  logic                             en_default;
  idx_t                             default_idx;
  logic                             config_ongoing;

  addr_map_regs u_addr_map_regs (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .cfg_we_i         (cfg_we_i),
    .cfg_wr_i         (cfg_wr_i),
    .addr_map_o       (addr_map),
    .en_default_o     (en_default),
    .default_idx_o    (default_idx),
    .config_ongoing_o (config_ongoing)
  );

  addr_req_router u_addr_req_router (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .req_valid_i      (req_valid_i),
    .req_i            (req_i),
    .addr_map_i       (addr_map),
    .en_default_i     (en_default),
    .default_idx_i    (default_idx),
    .config_ongoing_i (config_ongoing),
    .port_valid_o     (port_valid_o),
    .port_req_o       (port_req_o),
    .err_valid_o      (err_valid_o),
    .err_o            (err_o)
  );

endmodule

`default_nettype wire

// ==== verilog/addr_req_router.sv ====
// Request router
// Decodes each request strobe and issues a port strobe or an error strobe one cycle later
`timescale 1ns/100ps
`default_nettype none

`include "addr_xbar_consts.svh"

module addr_req_router (
  input  wire logic                                       clk_i,
  input  wire logic                                       arst_n_i,
  // Incoming request strobe
  input  wire logic                                       req_valid_i,
  input  addr_xbar_pkg::req_t                             req_i,
  // Live map from the register file
  input  addr_xbar_pkg::rule_t [`ADDR_XBAR_NUM_RULES-1:0] addr_map_i,
  input  wire logic                                       en_default_i,
  input  addr_xbar_pkg::idx_t                             default_idx_i,
  input  wire logic                                       config_ongoing_i,
  // One-hot port strobe with the forwarded request
  output logic [`ADDR_XBAR_NUM_PORTS-1:0]                 port_valid_o,
  output addr_xbar_pkg::req_t                             port_req_o,
  // Error strobe
  output logic                                            err_valid_o,
  output addr_xbar_pkg::err_t                             err_o
);

  import addr_xbar_pkg::*;

  idx_t dec_idx;
  logic dec_valid;
  logic dec_error;
  idx_t port_sel;

  logic [`ADDR_XBAR_NUM_PORTS-1:0] port_valid_d;
  logic                            err_valid_d;
  logic [`ADDR_XBAR_NUM_PORTS-1:0] port_valid_q;
  logic                            err_valid_q;

  // Request payload and busy flag, loaded with every strobe
  req_t req_q;
  logic busy_q;

  addr_decode_dync u_addr_decode_dync (
    .addr_i           (req_i.addr),
    .addr_map_i       (addr_map_i),
    .en_default_idx_i (en_default_i),
    .default_idx_i    (default_idx_i),
    .config_ongoing_i (config_ongoing_i),
    .idx_o            (dec_idx),
    .dec_valid_o      (dec_valid),
    .dec_error_o      (dec_error)
  );

  // A rule hit takes the rule's port, anything else falls back to the default
  assign port_sel = dec_valid ? dec_idx : default_idx_i;

  // Pick exactly one outcome for a valid strobe
  always_comb begin
    port_valid_d = '0;
    err_valid_d  = 1'b0;
    if (req_valid_i) begin
      if (config_ongoing_i) begin
        // Refused while the map is rewritten
        err_valid_d = 1'b1;
      end else if (dec_error) begin
        // No rule matched and no default port
        err_valid_d = 1'b1;
      end else begin
        port_valid_d = `ADDR_XBAR_NUM_PORTS'(1) << port_sel;
      end
    end
  end

  // Strobes last one cycle, so they are rebuilt at every edge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      port_valid_q <= '0;
      err_valid_q  <= 1'b0;
    end else begin
      port_valid_q <= port_valid_d;
      err_valid_q  <= err_valid_d;
    end
  end

  // Payload only changes with a new strobe
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      req_q  <= req_i;
      // Busy separates a refused request from a decode error
      busy_q <= config_ongoing_i;
    end
  end

  assign port_valid_o = port_valid_q;
  assign port_req_o   = req_q;
  assign err_valid_o  = err_valid_q;
  assign err_o.addr   = req_q.addr;
  assign err_o.busy   = busy_q;

endmodule

`default_nettype wire

// ==== verilog/addr_decode_dync.sv ====
// Dynamically configured range decoder
// Maps an address to a port index through the live rule array, zero latency
`timescale 1ns/100ps
`default_nettype none

`include "addr_xbar_consts.svh"

module addr_decode_dync (
  // Address to decode
  input  addr_xbar_pkg::addr_t                            addr_i,
  // Live map, the rule at the highest position wins on overlap
  input  addr_xbar_pkg::rule_t [`ADDR_XBAR_NUM_RULES-1:0] addr_map_i,
  // Map unmatched addresses to the default index
  input  wire logic                                       en_default_idx_i,
  input  addr_xbar_pkg::idx_t                             default_idx_i,
  // The map is being rewritten and cannot be trusted
  input  wire logic                                       config_ongoing_i,
  output addr_xbar_pkg::idx_t                             idx_o,
  output logic                                            dec_valid_o,
  output logic                                            dec_error_o
);

  import addr_xbar_pkg::*;

  logic rule_hit;

  always_comb begin
    // Without a match the default decides between a default index and an error
    rule_hit    = 1'b0;
    dec_valid_o = 1'b0;
    dec_error_o = !en_default_idx_i;
    idx_o       = en_default_idx_i ? default_idx_i : idx_t'(0);

    // Ascending scan, so a later match overrides an earlier one
    for (int unsigned i = 0; i < `ADDR_XBAR_NUM_RULES; i++) begin
      rule_hit = (addr_i >= addr_map_i[i].start_addr) &&
                 ((addr_i < addr_map_i[i].end_addr) ||
                  (addr_map_i[i].end_addr == addr_t'(0)));
      if (rule_hit) begin
        dec_valid_o = 1'b1;
        dec_error_o = 1'b0;
        idx_o       = addr_map_i[i].idx;
      end
    end

    // While an update is open the result is held off
    // A match still clears the error, the caller refuses the request itself
    if (config_ongoing_i) begin
      dec_valid_o = 1'b0;
      idx_o       = default_idx_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/addr_map_regs.sv ====
// Address map register file
// Holds the live range rules and the default port, and tracks open map updates
`timescale 1ns/100ps
`default_nettype none

`include "addr_xbar_consts.svh"

module addr_map_regs (
  input  wire logic                                               clk_i,
  input  wire logic                                               arst_n_i,
  input  wire logic                                               cfg_we_i,
  input  addr_xbar_pkg::cfg_wr_t                                  cfg_wr_i,
  output addr_xbar_pkg::rule_t [`ADDR_XBAR_NUM_RULES-1:0]         addr_map_o,
  output logic                                                    en_default_o,
  output addr_xbar_pkg::idx_t                                     default_idx_o,
  output logic                                                    config_ongoing_o
);

  import addr_xbar_pkg::*;

  // Register offset layout
  // The low bits pick a field inside a rule, the bits above pick the rule
  localparam int unsigned FLD_W      = $clog2(`ADDR_XBAR_RULE_STRIDE);
  localparam int unsigned RULE_IDX_W = $clog2(`ADDR_XBAR_NUM_RULES);
  localparam int unsigned RULE_REGS  = `ADDR_XBAR_NUM_RULES * `ADDR_XBAR_RULE_STRIDE;

  rule_t [`ADDR_XBAR_NUM_RULES-1:0] rules_q;
  logic                             en_default_q;
  idx_t                             default_idx_q;
  cfg_state_e                       state_q;
  cfg_state_e                       state_d;

  logic                  rule_wr;
  logic                  ctrl_wr;
  logic                  commit_wr;
  logic [RULE_IDX_W-1:0] rule_sel;
  logic [FLD_W-1:0]      field_sel;

  // Split the offset into rule number and field number
  assign field_sel = cfg_wr_i.reg_addr[FLD_W-1:0];
  assign rule_sel  = cfg_wr_i.reg_addr[FLD_W +: RULE_IDX_W];

  // A rule write needs an offset inside the rule block and a defined field
  // The spare field slot of each rule is ignored like any other unused offset
  assign rule_wr = cfg_we_i && (cfg_wr_i.reg_addr < cfg_addr_t'(RULE_REGS)) &&
                   ((field_sel == FLD_W'(`ADDR_XBAR_FLD_START)) ||
                    (field_sel == FLD_W'(`ADDR_XBAR_FLD_END)) ||
                    (field_sel == FLD_W'(`ADDR_XBAR_FLD_IDX)));

  assign ctrl_wr   = cfg_we_i && (cfg_wr_i.reg_addr == cfg_addr_t'(`ADDR_XBAR_REG_CTRL));
  assign commit_wr = cfg_we_i && (cfg_wr_i.reg_addr == cfg_addr_t'(`ADDR_XBAR_REG_COMMIT));

  // One register slice per rule, each written in place
  for (genvar r = 0; r < `ADDR_XBAR_NUM_RULES; r++) begin : g_rule
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        // Start equal to end leaves the rule empty, so nothing decodes yet
        rules_q[r].idx        <= '0;
        rules_q[r].start_addr <= addr_t'(1);
        rules_q[r].end_addr   <= addr_t'(1);
      end else if (rule_wr && (rule_sel == RULE_IDX_W'(r))) begin
        case (field_sel)
          FLD_W'(`ADDR_XBAR_FLD_START): begin
            rules_q[r].start_addr <= addr_t'(cfg_wr_i.wdata);
          end
          FLD_W'(`ADDR_XBAR_FLD_END): begin
            rules_q[r].end_addr <= addr_t'(cfg_wr_i.wdata);
          end
          default: begin
            // Only the index field is left once rule_wr has filtered the offset
            rules_q[r].idx <= cfg_wr_i.wdata[`ADDR_XBAR_IDX_WIDTH-1:0];
          end
        endcase
      end
    end
  end

  // Control register with the default port setting
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_default_q  <= 1'b0;
      default_idx_q <= '0;
    end else if (ctrl_wr) begin
      en_default_q  <= cfg_wr_i.wdata[0];
      default_idx_q <= cfg_wr_i.wdata[`ADDR_XBAR_IDX_WIDTH:1];
    end
  end

  // Update FSM
  // The first rule write opens an update and the commit write closes it
  always_comb begin
    state_d = state_q;
    case (state_q)
      CFG_IDLE: begin
        if (rule_wr) begin
          state_d = CFG_UPDATING;
        end
      end
      CFG_UPDATING: begin
        if (commit_wr) begin
          state_d = CFG_IDLE;
        end
      end
      default: begin
        state_d = CFG_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= CFG_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // All map outputs come straight from registers
  assign addr_map_o       = rules_q;
  assign en_default_o     = en_default_q;
  assign default_idx_o    = default_idx_q;
  assign config_ongoing_o = (state_q == CFG_UPDATING);

endmodule

`default_nettype wire

// ==== verilog/addr_xbar_pkg.sv ====
// Address crossbar types
// Shared by the register file, the decoder and the router
`default_nettype none

`include "addr_xbar_consts.svh"

package addr_xbar_pkg;

  // Plain vectors for the request fields and the port index
  typedef logic [`ADDR_XBAR_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`ADDR_XBAR_DATA_WIDTH-1:0] data_t;
  typedef logic [`ADDR_XBAR_IDX_WIDTH-1:0] idx_t;
  typedef logic [`ADDR_XBAR_CFG_ADDR_WIDTH-1:0] cfg_addr_t;

  // One range rule of the address map
  // Start is inclusive, end is exclusive and an end of zero reaches the top
  typedef struct packed {
    idx_t  idx;
    addr_t start_addr;
    addr_t end_addr;
  } rule_t;

  // A request strobe carries one address and one data word
  typedef struct packed {
    addr_t addr;
    data_t data;
  } req_t;

  // Error strobe payload
  // Busy marks a request refused while the map was being rewritten
  typedef struct packed {
    addr_t addr;
    logic  busy;
  } err_t;

  // Single-cycle configuration write
  typedef struct packed {
    cfg_addr_t reg_addr;
    data_t     wdata;
  } cfg_wr_t;

  // Map update tracking
  typedef enum logic {
    CFG_IDLE,
    CFG_UPDATING
  } cfg_state_e;

endpackage

`default_nettype wire

// ==== verilog/addr_xbar_consts.svh ====
// Address crossbar constants
// Widths, rule and port counts, and the configuration register map
`ifndef ADDR_XBAR_CONSTS_SVH
`define ADDR_XBAR_CONSTS_SVH

// Request address and data widths
`define ADDR_XBAR_ADDR_WIDTH 32
`define ADDR_XBAR_DATA_WIDTH 32

// Size of the live address map and number of output ports
`define ADDR_XBAR_NUM_RULES 4
`define ADDR_XBAR_NUM_PORTS 4
`define ADDR_XBAR_IDX_WIDTH 2

// Configuration register space
`define ADDR_XBAR_CFG_ADDR_WIDTH 5
`define ADDR_XBAR_RULE_STRIDE 4
`define ADDR_XBAR_FLD_START 0
`define ADDR_XBAR_FLD_END 1
`define ADDR_XBAR_FLD_IDX 2
// Control register, bit 0 enables the default port and bits 2:1 select it
`define ADDR_XBAR_REG_CTRL 16
// Any write here closes an open map update
`define ADDR_XBAR_REG_COMMIT 17

`endif
